// ==== filelist.f ====
hdl/int_div_pkg.sv
hdl/div_opnd_if.sv
hdl/div_operand_prep.sv
hdl/divstage64.sv
hdl/div_iter_reg.sv
hdl/div_result_fix.sv
hdl/div_ctrl.sv
hdl/int_div_top.sv
sim/tb_int_div.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_int_div
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_int_div.sv ====
/*
 * testbench of the 64-bit integer divide unit
 *   reference model by the RISC-V divide and remainder rules
 *   unsigned, signed, special case, word mode and timing tests
 *   concurrent and immediate assertions, watchdog and report
 */

`default_nettype none

module tb_int_div import int_div_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 5;
    localparam int LATENCY    = 17;
    localparam int MAX_WAIT   = 40;
    localparam int N_RAND     = 20;
    localparam int N_WORD     = 8;
    // one extra op for the idle window after the ignored start
    localparam int N_OPS      = 12 + 2 * N_RAND + 16 + 12 + 4 * N_WORD + 2;
    localparam int WATCHDOG   = (N_OPS * 20 + RST_CYCLES) * CLK_PERIOD;
    localparam logic [63:0] ONES = 64'hffff_ffff_ffff_ffff;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        start;
    div_op_e     op;
    logic        word;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic        busy;
    logic        valid;

    integer seed;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     valid_pulses = 0;

    int_div_top i_int_div_top (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .op     (op),
        .word   (word),
        .a      (a),
        .b      (b),
        .res    (res),
        .busy   (busy),
        .valid  (valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (valid) begin
            valid_pulses <= valid_pulses + 1;
        end
    end

    valid_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) valid |=> !valid)
        else begin
            $display("Fail %0t: valid stayed high for more than one cycle", $time);
            errors++;
        end

    idle_when_valid: assert property (@(posedge clk) disable iff (!arst_n) valid |-> !busy)
        else begin
            $display("Fail %0t: busy high in the valid cycle", $time);
            errors++;
        end

    busy_after_start: assert property (@(posedge clk) disable iff (!arst_n)
        (start && !busy) |=> busy)
        else begin
            $display("Fail %0t: busy did not rise after an accepted start", $time);
            errors++;
        end

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // RISC-V results, including division by zero and signed overflow
    function automatic logic [63:0] expected_result(div_op_e op_i, logic word_i,
                                                    logic [63:0] a_i, logic [63:0] b_i);
        logic        sgn;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] q;
        logic [63:0] r;
        logic [63:0] out;
        sgn = (op_i == OP_DIV) || (op_i == OP_REM);
        x = a_i;
        y = b_i;
        if (word_i) begin
            x = sgn ? {{32{a_i[31]}}, a_i[31:0]} : {32'b0, a_i[31:0]};
            y = sgn ? {{32{b_i[31]}}, b_i[31:0]} : {32'b0, b_i[31:0]};
        end
        if (y == 64'd0) begin
            q = ONES;
            r = x;
        end else if (!sgn) begin
            q = x / y;
            r = x % y;
        end else if (x == {1'b1, 63'b0} && y == ONES) begin
            q = x;
            r = 64'd0;
        end else begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end
        out = ((op_i == OP_REM) || (op_i == OP_REMU)) ? r : q;
        if (word_i) begin
            out = {{32{out[31]}}, out[31:0]};
        end
        return out;
    endfunction

    task automatic drive_noise(input logic start_v);
        start = start_v;
        op    = div_op_e'(2'($random(seed)));
        word  = 1'($random(seed));
        a     = rand64();
        b     = rand64();
    endtask

    // issues one op, scrambles the inputs while busy and checks the result
    // cycles counts rising edges since the start edge, zero busy_start_at means no extra start
    task automatic run_op(input div_op_e op_i, input logic word_i, input logic [63:0] a_i,
                          input logic [63:0] b_i, input int busy_start_at);
        logic [63:0] exp_res;
        int          cycles;
        int          pulses_before;
        exp_res = expected_result(op_i, word_i, a_i, b_i);
        @(negedge clk);
        assert (!busy) else begin
            $display("Fail %0t: busy still high when a new operation was issued", $time);
            errors++;
        end
        start = 1'b1;
        op    = op_i;
        word  = word_i;
        a     = a_i;
        b     = b_i;
        pulses_before = valid_pulses;
        @(negedge clk);
        cycles = 0;
        while (!valid && cycles < MAX_WAIT) begin
            assert (busy) else begin
                $display("Fail %0t: busy low %0d cycles after start", $time, cycles);
                errors++;
            end
            drive_noise(busy_start_at > 0 && cycles == busy_start_at);
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        if (!valid) begin
            $display("no valid pulse within %0d cycles of start", MAX_WAIT);
            errors++;
        end else begin
            assert (cycles == LATENCY) else begin
                $display("Fail %0t: valid after %0d cycles, expected %0d", $time, cycles,
                         LATENCY);
                errors++;
            end
            assert (res == exp_res) else begin
                $display("Fail %0t: op %s word %b a 0x%h b 0x%h res 0x%h expected 0x%h",
                         $time, op_i.name(), word_i, a_i, b_i, res, exp_res);
                errors++;
            end
            assert (valid_pulses == pulses_before) else begin
                $display("Fail %0t: extra valid pulse during the operation", $time);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s done, no errors", name);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_unsigned_edge();
        logic [63:0] ea [6];
        logic [63:0] eb [6];
        ea = '{64'd0, 64'hdead_beef_0123_4567, 64'd100, ONES, ONES, ONES};
        eb = '{64'd12345, 64'd1, 64'hffff_0000_0000_0001, ONES, 64'd1, 64'd3};
        for (int i = 0; i < 6; i++) begin
            run_op(OP_DIVU, 1'b0, ea[i], eb[i], 0);
            run_op(OP_REMU, 1'b0, ea[i], eb[i], 0);
        end
    endtask

    task automatic test_unsigned_random();
        logic [63:0] x;
        logic [63:0] y;
        for (int i = 0; i < N_RAND; i++) begin
            x = rand64();
            y = rand64() >> (3 * i);
            run_op(OP_DIVU, 1'b0, x, y, 0);
            run_op(OP_REMU, 1'b0, x, y, 0);
        end
    endtask

    // all four sign combinations, small exact values first
    task automatic test_signed();
        logic [63:0] ma;
        logic [63:0] mb;
        logic [63:0] x;
        logic [63:0] y;
        for (int i = 0; i < 8; i++) begin
            ma = (i < 4) ? 64'd7 : rand64() >> 1;
            mb = (i < 4) ? 64'd2 : (rand64() >> (4 * i)) | 64'd1;
            x  = (i % 2 == 1) ? -ma : ma;
            y  = ((i / 2) % 2 == 1) ? -mb : mb;
            run_op(OP_DIV, 1'b0, x, y, 0);
            run_op(OP_REM, 1'b0, x, y, 0);
        end
    endtask

    task automatic test_special();
        logic        wm;
        logic [63:0] x;
        logic [63:0] zero_b;
        logic [63:0] mn;
        logic [63:0] m1;
        for (int w = 0; w < 2; w++) begin
            wm     = (w == 1);
            x      = rand64() | 64'h8000_0000_8000_0000;
            zero_b = wm ? 64'h5555_0000_0000_0000 : 64'd0;
            mn     = wm ? 64'h1234_5678_8000_0000 : 64'h8000_0000_0000_0000;
            m1     = wm ? 64'habcd_0000_ffff_ffff : ONES;
            for (int k = 0; k < 4; k++) begin
                run_op(div_op_e'(2'(k)), wm, x, zero_b, 0);
            end
            run_op(OP_DIV, wm, mn, m1, 0);
            run_op(OP_REM, wm, mn, m1, 0);
        end
    endtask

    task automatic test_word_random();
        logic [63:0] x;
        logic [63:0] y;
        for (int i = 0; i < N_WORD; i++) begin
            x = rand64() | 64'h0000_0100_0000_0000;
            y = rand64() | 64'h0001_0000_0000_0000;
            y[31:0] = y[31:0] >> (3 * i);
            for (int k = 0; k < 4; k++) begin
                run_op(div_op_e'(2'(k)), 1'b1, x, y, 0);
            end
        end
    endtask

    task automatic test_timing();
        run_op(OP_DIVU, 1'b0, rand64(), rand64() >> 20, 6);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!valid && !busy) else begin
                $display("Fail %0t: a start given while busy launched another operation",
                         $time);
                errors++;
            end
        end
    endtask

    initial begin
        #(WATCHDOG);
        $display("timeout, the tests did not finish within %0d time units", WATCHDOG);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int errs;
        seed   = 26659;
        arst_n = 1'b0;
        start  = 1'b0;
        op     = OP_DIV;
        word   = 1'b0;
        a      = 64'd0;
        b      = 64'd0;
        errs   = errors;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (!busy && !valid && res == 64'd0) else begin
            $display("Fail %0t: busy %b valid %b res 0x%h after reset", $time, busy, valid, res);
            errors++;
        end
        report_test("reset", errs);
        errs = errors;
        test_unsigned_edge();
        report_test("unsigned edge values", errs);
        errs = errors;
        test_unsigned_random();
        report_test("unsigned random", errs);
        errs = errors;
        test_signed();
        report_test("signed", errs);
        errs = errors;
        test_special();
        report_test("zero divisor and overflow", errs);
        errs = errors;
        test_word_random();
        report_test("word mode random", errs);
        errs = errors;
        test_timing();
        report_test("start while busy", errs);
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_int_div

`default_nettype wire

// ==== hdl/int_div_top.sv ====
/*
 * 64-bit integer divide unit, top level
 *   control FSM, operand block, iteration registers, result block
 *   DIV, DIVU, REM, REMU and their word forms, 17 cycles per op
 */

`default_nettype none

module int_div_top import int_div_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  div_op_e         op,
    input  logic            word,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] res,
    output logic            busy,
    output logic            valid
);

    logic            load;
    logic            step;
    logic            capture;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;

    div_opnd_if opnd ();

    div_ctrl i_div_ctrl (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .load    (load),
        .step    (step),
        .capture (capture),
        .busy    (busy),
        .valid   (valid)
    );

    div_operand_prep i_div_operand_prep (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load),
        .op     (op),
        .word   (word),
        .a      (a),
        .b      (b),
        .opnd   (opnd.prep)
    );

    div_iter_reg i_div_iter_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (load),
        .step   (step),
        .opnd   (opnd.dp),
        .quot   (quot),
        .rem    (rem)
    );

    div_result_fix i_div_result_fix (
        .clk     (clk),
        .arst_n  (arst_n),
        .capture (capture),
        .opnd    (opnd.dp),
        .quot    (quot),
        .rem     (rem),
        .res     (res)
    );

endmodule : int_div_top

`default_nettype wire

// ==== hdl/div_ctrl.sv ====
/*
 * control FSM of the divider
 *   idle, run and fix states with the iteration counter
 *   load, step and capture strobes, busy and valid
 */

`default_nettype none

module div_ctrl import int_div_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic load,
    output logic step,
    output logic capture,
    output logic busy,
    output logic valid
);

    div_state_e state;
    logic [3:0] cnt;

    // start counts only while idle
    assign load    = start && (state == ST_IDLE);
    assign step    = (state == ST_RUN);
    assign capture = (state == ST_FIX);
    assign busy    = (state != ST_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
            valid <= 1'b0;
        end else begin
            // valid follows the capture cycle
            valid <= capture;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'(N_ITER - 1)) begin
                        state <= ST_FIX;
                    end
                end
                ST_FIX: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule : div_ctrl

`default_nettype wire

// ==== hdl/div_result_fix.sv ====
/*
 * result correction and register
 *   quotient or remainder select with sign fix
 *   sign extension of word results
 */

`default_nettype none

module div_result_fix import int_div_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            capture,
    div_opnd_if.dp          opnd,
    input  logic [XLEN-1:0] quot,
    input  logic [XLEN-1:0] rem,
    output logic [XLEN-1:0] res
);

    logic [XLEN-1:0] mag;
    logic            neg;
    logic [XLEN-1:0] signed_val;
    logic [XLEN-1:0] res_d;

    assign mag = opnd.sel_rem ? rem : quot;
    assign neg = opnd.sel_rem ? opnd.neg_r : opnd.neg_q;

    assign signed_val = neg ? (~mag + 1'b1) : mag;

    // word ops return the low half sign extended, also for the unsigned forms
    assign res_d = opnd.word ? {{32{signed_val[31]}}, signed_val[31:0]} : signed_val;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res <= '0;
        end else if (capture) begin
            res <= res_d;
        end
    end

endmodule : div_result_fix

`default_nettype wire

// ==== hdl/div_iter_reg.sv ====
/*
 * iteration registers of the divider
 *   residual, shifting divisor and growing quotient
 *   one radix-16 stage per step
 */

`default_nettype none

module div_iter_reg import int_div_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load,
    input  logic            step,
    div_opnd_if.dp          opnd,
    output logic [XLEN-1:0] quot,
    output logic [XLEN-1:0] rem
);

    logic [XLEN-1:0]   resid_q;
    logic [DIVX_W-1:0] divx_q;
    logic [XLEN-1:0]   quot_q;
    logic [XLEN-1:0]   stage_resid;
    logic [3:0]        stage_bits;

    divstage64 i_divstage64 (
        .divident (resid_q),
        .divisor  (divx_q),
        .resid    (stage_resid),
        .bits     (stage_bits)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resid_q <= '0;
            divx_q  <= '0;
            quot_q  <= '0;
        end else if (load) begin
            resid_q <= opnd.abs_a;
            // first stage works on the top nibble of the dividend
            divx_q  <= {opnd.abs_b, {(DIVX_W-XLEN){1'b0}}};
            quot_q  <= '0;
        end else if (step) begin
            resid_q <= stage_resid;
            divx_q  <= divx_q >> 4;
            quot_q  <= {quot_q[XLEN-5:0], stage_bits};
        end
    end

    assign quot = quot_q;
    // the residual left after the last step is the remainder
    assign rem  = resid_q;

endmodule : div_iter_reg

`default_nettype wire

// ==== hdl/divstage64.sv ====
/*
 * radix-16 divider stage
 *   1 to 15 times the shifted divisor from shifts, adds and subtracts
 *   residual compare against every multiple
 *   four quotient bits and the new residual
 */

`default_nettype none

module divstage64 import int_div_pkg::*; (
    input  logic [XLEN-1:0]   divident,
    input  logic [DIVX_W-1:0] divisor,
    output logic [XLEN-1:0]   resid,
    output logic [3:0]        bits
);

    // saturation flags, set when k times the divisor exceeds 64 bits
    logic sat1;
    logic sat2;
    logic sat4;
    logic sat8;
    logic sat16;

    logic [XLEN:0]   mult [1:15];
    logic [XLEN:0]   mult16;
    logic [XLEN+1:0] diff [1:15];

    assign sat1  = |divisor[DIVX_W-1:XLEN];
    assign sat2  = |divisor[DIVX_W-1:XLEN-1];
    assign sat4  = |divisor[DIVX_W-1:XLEN-2];
    assign sat8  = |divisor[DIVX_W-1:XLEN-3];
    assign sat16 = |divisor[DIVX_W-1:XLEN-4];

    always_comb begin
        // powers of two are plain shifts
        mult[1]  = {sat1, divisor[XLEN-1:0]};
        mult[2]  = {sat2, divisor[XLEN-2:0], 1'b0};
        mult[4]  = {sat4, divisor[XLEN-3:0], 2'b0};
        mult[8]  = {sat8, divisor[XLEN-4:0], 3'b0};
        mult16   = {sat16, divisor[XLEN-5:0], 4'b0};

        mult[3]  = {1'b0, mult[2][XLEN-1:0]} + {1'b0, mult[1][XLEN-1:0]};
        mult[3][XLEN] = mult[3][XLEN] | mult[2][XLEN];

        mult[5]  = {1'b0, mult[4][XLEN-1:0]} + {1'b0, mult[1][XLEN-1:0]};
        mult[5][XLEN] = mult[5][XLEN] | mult[4][XLEN];

        mult[6]  = {mult[3][XLEN] | mult[3][XLEN-1], mult[3][XLEN-2:0], 1'b0};

        // 7 = 8 - 1, the full 65-bit multiple of 8 keeps this exact
        mult[7]  = mult[8] - {1'b0, mult[1][XLEN-1:0]};
        mult[7][XLEN] = mult[7][XLEN] | sat4;

        mult[9]  = {1'b0, mult[8][XLEN-1:0]} + {1'b0, mult[1][XLEN-1:0]};
        mult[9][XLEN] = mult[9][XLEN] | sat8;

        mult[10] = {1'b0, mult[8][XLEN-1:0]} + {1'b0, mult[2][XLEN-1:0]};
        mult[10][XLEN] = mult[10][XLEN] | sat8;

        mult[11] = {1'b0, mult[8][XLEN-1:0]} + {1'b0, mult[3][XLEN-1:0]};
        mult[11][XLEN] = mult[11][XLEN] | sat8;

        mult[12] = {|mult[3][XLEN:XLEN-2], mult[3][XLEN-3:0], 2'b0};

        // 13 = 16 - 3
        mult[13] = mult16 - {1'b0, mult[3][XLEN-1:0]};
        mult[13][XLEN] = mult[13][XLEN] | sat8;

        mult[14] = {mult[7][XLEN] | mult[7][XLEN-1], mult[7][XLEN-2:0], 1'b0};

        // 15 = 16 - 1
        mult[15] = mult16 - {1'b0, mult[1][XLEN-1:0]};
        mult[15][XLEN] = mult[15][XLEN] | sat8;
    end

    always_comb begin
        for (int i = 1; i < 16; i++) begin
            diff[i] = {2'b0, divident} - {1'b0, mult[i]};
        end
    end

    // differences fall with the multiple, so the last nonnegative one wins
    always_comb begin
        bits  = 4'd0;
        resid = divident;
        for (int i = 1; i < 16; i++) begin
            if (!diff[i][XLEN+1]) begin
                bits  = 4'(i);
                resid = diff[i][XLEN-1:0];
            end
        end
    end

endmodule : divstage64

`default_nettype wire

// ==== hdl/div_operand_prep.sv ====
/*
 * operand preparation
 *   word mode sign or zero extension of both operands
 *   two's complement magnitudes for signed ops
 *   result sign, select and word flags latched on load
 */

`default_nettype none

module div_operand_prep import int_div_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load,
    input  div_op_e         op,
    input  logic            word,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    div_opnd_if.prep        opnd
);

    logic            is_signed;
    logic [XLEN-1:0] ext_a;
    logic [XLEN-1:0] ext_b;
    logic            sign_a;
    logic            sign_b;
    logic            b_zero;

    assign is_signed = (op == OP_DIV) || (op == OP_REM);

    always_comb begin
        if (word && is_signed) begin
            ext_a = {{32{a[31]}}, a[31:0]};
            ext_b = {{32{b[31]}}, b[31:0]};
        end else if (word) begin
            ext_a = {32'b0, a[31:0]};
            ext_b = {32'b0, b[31:0]};
        end else begin
            ext_a = a;
            ext_b = b;
        end
    end

    // after extension bit 63 carries the sign in both modes
    assign sign_a = is_signed && ext_a[XLEN-1];
    assign sign_b = is_signed && ext_b[XLEN-1];
    assign b_zero = (ext_b == '0);

    assign opnd.abs_a = sign_a ? (~ext_a + 1'b1) : ext_a;
    assign opnd.abs_b = sign_b ? (~ext_b + 1'b1) : ext_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opnd.neg_q   <= 1'b0;
            opnd.neg_r   <= 1'b0;
            opnd.sel_rem <= 1'b0;
            opnd.word    <= 1'b0;
        end else if (load) begin
            // a zero divisor keeps the all ones quotient positive
            opnd.neg_q   <= (sign_a ^ sign_b) && !b_zero;
            opnd.neg_r   <= sign_a;
            opnd.sel_rem <= (op == OP_REM) || (op == OP_REMU);
            opnd.word    <= word;
        end
    end

endmodule : div_operand_prep

`default_nettype wire

// ==== hdl/div_opnd_if.sv ====
/*
 * operand bundle between the operand block and the datapath
 * magnitudes are combinational, sign and mode flags are latched at start
 */

`default_nettype none

interface div_opnd_if import int_div_pkg::*; ();

    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;
    logic            neg_q;
    logic            neg_r;
    logic            sel_rem;
    logic            word;

    modport prep (
        output abs_a, abs_b,
        output neg_q, neg_r, sel_rem, word
    );

    // iteration registers take the magnitudes, the result block the flags
    modport dp (
        input abs_a, abs_b,
        input neg_q, neg_r, sel_rem, word
    );

endinterface : div_opnd_if

`default_nettype wire

// ==== hdl/int_div_pkg.sv ====
/*
 * shared definitions of the integer divide unit
 *   div_op_e    : divide and remainder opcodes
 *   div_state_e : states of the control FSM
 *   XLEN, DIVX_W, N_ITER : data width, shifted divisor width, iteration count
 */

`default_nettype none

package int_div_pkg;

    localparam int XLEN = 64;

    // divisor starts shifted left by 60 so the first stage sees the top nibble
    localparam int DIVX_W = XLEN + 60;

    // four quotient bits per radix-16 iteration
    localparam int N_ITER = XLEN / 4;

    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_FIX  = 2'd2
    } div_state_e;

endpackage : int_div_pkg

`default_nettype wire
